// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the speaker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module speaker_tb -f sim.f -o speaker_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/speaker_sim)
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$sim_out" | grep -q 'All tests passed!'; then
	exit 0
fi
exit 1

// File: sim.f
+incdir+source
source/tone_pkg.sv
source/audio_pkg.sv
source/keypad_scan.sv
source/tone_setting.sv
source/buzzer_control.sv
source/speaker_control.sv
source/speaker.sv
tb/speaker_tb.sv

// File: source/audio_pkg.sv
`default_nettype none

package audio_pkg;

	// Left sample sits in the upper half so it goes out first
	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} sample_t;

	// Serializer phases
	typedef enum logic [1:0] {
		DAC_IDLE,
		DAC_LEFT,
		DAC_RIGHT
	} dac_state_t;

endpackage

`default_nettype wire

// File: source/buzzer_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "speaker_macros.svh"

module buzzer_control (
	input logic clk,
	input logic rst_n,
	input logic [19:0] note_div,
	output logic signed [15:0] audio_tone
);

	localparam logic signed [15:0] VOL = `VOLUME;

	logic [19:0] div_q;
	logic [19:0] cnt;
	logic polarity;

	////////////////////////////////////////////////
	// Half-period counter
	////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q <= 20'd0;
			cnt <= 20'd0;
			polarity <= 1'b0;
		end else if (note_div != div_q) begin
			// New note restarts the wave from its positive half
			div_q <= note_div;
			cnt <= 20'd0;
			polarity <= 1'b0;
		end else if (div_q == 20'd0) begin
			cnt <= 20'd0;
			polarity <= 1'b0;
		end else if (cnt == div_q - 20'd1) begin
			cnt <= 20'd0;
			polarity <= ~polarity;
		end else begin
			cnt <= cnt + 20'd1;
		end
	end

	// Silent while no divisor is loaded
	always_comb begin
		if (div_q == 20'd0)
			audio_tone = 16'sd0;
		else if (polarity)
			audio_tone = -VOL;
		else
			audio_tone = VOL;
	end

endmodule

`default_nettype wire

// File: source/keypad_scan.sv
`timescale 1ns/100ps
`default_nettype none

`include "speaker_macros.svh"

module keypad_scan import tone_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [3:0] col_in,
	output logic [3:0] row_scn,
	output key_t key,
	output logic pressed
);

	logic [7:0] tick_cnt;
	logic [1:0] row_idx;
	logic row_end;
	logic col_hit;
	logic [1:0] col_idx;
	logic scan_hit;
	key_t scan_key;
	key_t row_key;

	assign row_end = (tick_cnt == 8'(`SCAN_TICKS - 1));

	// Lowest active-low column wins
	always_comb begin
		col_idx = 2'd0;
		for (int c = 3; c >= 0; c--) begin
			if (!col_in[c])
				col_idx = 2'(c);
		end
	end

	assign col_hit = (col_in != 4'hF);
	assign row_key = {row_idx, col_idx};

	////////////////////////////////////////////////
	// Row rotation and per-scan key capture
	////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= 8'd0;
			row_idx <= 2'd0;
			row_scn <= 4'b1110;
			scan_hit <= 1'b0;
			scan_key <= 4'd0;
			key <= 4'd0;
			pressed <= 1'b0;
		end else if (row_end) begin
			tick_cnt <= 8'd0;
			row_idx <= row_idx + 2'd1;
			row_scn <= {row_scn[2:0], row_scn[3]};
			if (row_idx == 2'd3) begin
				// Publish what this scan found after the last row
				pressed <= scan_hit | col_hit;
				if (scan_hit)
					key <= scan_key;
				else if (col_hit)
					key <= row_key;
				scan_hit <= 1'b0;
			end else if (!scan_hit && col_hit) begin
				scan_hit <= 1'b1;
				scan_key <= row_key;
			end
		end else begin
			tick_cnt <= tick_cnt + 8'd1;
		end
	end

	// One row low and it is the row being decoded
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~row_scn) && !row_scn[row_idx]);

endmodule

`default_nettype wire

// File: source/speaker.sv
`timescale 1ns/100ps
`default_nettype none

`include "speaker_macros.svh"

module speaker import tone_pkg::*, audio_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic chorus,
	input logic [3:0] col_in,
	output logic [3:0] row_scn,
	output logic audio_appsel,
	output logic audio_sysclk,
	output logic audio_bck,
	output logic audio_ws,
	output logic audio_data
);

	key_t key;
	logic pressed;
	note_div_t note_div;
	sample_t audio_sample;

	keypad_scan pad_scn (
		.clk(clk),
		.rst_n(rst_n),
		.col_in(col_in),
		.row_scn(row_scn),
		.key(key),
		.pressed(pressed)
	);

	tone_setting tone_set (
		.clk(clk),
		.rst_n(rst_n),
		.key(key),
		.pressed(pressed),
		.chorus(chorus),
		.note_div(note_div)
	);

	// One generator per channel
	buzzer_control buz_ctl_left (
		.clk(clk),
		.rst_n(rst_n),
		.note_div(note_div.left),
		.audio_tone(audio_sample.left)
	);

	buzzer_control buz_ctl_right (
		.clk(clk),
		.rst_n(rst_n),
		.note_div(note_div.right),
		.audio_tone(audio_sample.right)
	);

	speaker_control spk_ctl (
		.clk(clk),
		.rst_n(rst_n),
		.audio_in(audio_sample),
		.audio_appsel(audio_appsel),
		.audio_sysclk(audio_sysclk),
		.audio_bck(audio_bck),
		.audio_ws(audio_ws),
		.audio_data(audio_data)
	);

endmodule

`default_nettype wire

// File: source/speaker_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "speaker_macros.svh"

module speaker_control import audio_pkg::*; (
	input logic clk,
	input logic rst_n,
	input sample_t audio_in,
	output logic audio_appsel,
	output logic audio_sysclk,
	output logic audio_bck,
	output logic audio_ws,
	output logic audio_data
);

	// Bit and frame lengths must be powers of two
	localparam int BIT_CYCLES = 2 * `BCK_DIV;
	localparam int FRAME_CYCLES = 32 * BIT_CYCLES;
	localparam int CNT_W = $clog2(FRAME_CYCLES);
	localparam int PH_W = $clog2(BIT_CYCLES);

	logic [CNT_W-1:0] cnt;
	logic [PH_W-1:0] bit_phase;
	logic [4:0] bit_num;
	logic bit_end;
	logic frame_end;
	dac_state_t state;
	logic [31:0] shreg;

	assign bit_phase = cnt[PH_W-1:0];
	assign bit_num = cnt[CNT_W-1:PH_W];
	assign bit_end = (bit_phase == PH_W'(BIT_CYCLES - 1));
	assign frame_end = (cnt == CNT_W'(FRAME_CYCLES - 1));

	////////////////////////////////////////////////
	// DAC clocks from the frame counter
	////////////////////////////////////////////////
	assign audio_appsel = 1'b1;
	assign audio_sysclk = cnt[0];
	assign audio_bck = (bit_phase >= PH_W'(`BCK_DIV));
	assign audio_ws = bit_num[4];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Serializer state goes left half then right half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= DAC_IDLE;
		else if (frame_end)
			state <= DAC_LEFT;
		else if (state == DAC_LEFT && bit_end && bit_num == 5'd15)
			state <= DAC_RIGHT;
	end

	// Load at the end of a frame so bit 0 is ready on the first falling edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shreg <= '0;
		else if (frame_end)
			shreg <= audio_in;
		else if (bit_end)
			shreg <= {shreg[30:0], 1'b0};
	end

	assign audio_data = (state == DAC_IDLE) ? 1'b0 : shreg[31];

	// Word select moves only with the falling bit clock
	assert property (@(posedge clk) disable iff (!rst_n)
		$changed(audio_ws) |-> $fell(audio_bck));

endmodule

`default_nettype wire

// File: source/speaker_macros.svh
`ifndef SPEAKER_MACROS_SVH
`define SPEAKER_MACROS_SVH

// Clock cycles each keypad row stays driven low
`define SCAN_TICKS 16

// Clock cycles per half DAC bit clock
`define BCK_DIV 2

// Square wave amplitude
`define VOLUME 16'h3FFF

// Right shift on the note divisors to keep simulation runs short
`define NOTE_SCALE 6

`endif

// File: source/tone_pkg.sv
`default_nettype none

package tone_pkg;

	// Keypad code is row * 4 + column
	typedef logic [3:0] key_t;

	// One octave of notes plus silence
	typedef enum logic [3:0] {
		NOTE_C,
		NOTE_CS,
		NOTE_D,
		NOTE_DS,
		NOTE_E,
		NOTE_F,
		NOTE_FS,
		NOTE_G,
		NOTE_GS,
		NOTE_A,
		NOTE_AS,
		NOTE_B,
		NOTE_REST
	} note_t;

	// Half-period divisors in clock cycles where zero is silence
	typedef struct packed {
		logic [19:0] left;
		logic [19:0] right;
	} note_div_t;

endpackage

`default_nettype wire

// File: source/tone_setting.sv
`timescale 1ns/100ps
`default_nettype none

`include "speaker_macros.svh"

module tone_setting import tone_pkg::*; (
	input logic clk,
	input logic rst_n,
	input key_t key,
	input logic pressed,
	input logic chorus,
	output note_div_t note_div
);

	note_t note_left;
	note_t note_right;

	// Fourth octave half periods at 100 MHz before scaling
	function automatic logic [19:0] half_period(input note_t note);
		logic [19:0] full;
		case (note)
			NOTE_C: full = 20'd191110;
			NOTE_CS: full = 20'd180388;
			NOTE_D: full = 20'd170265;
			NOTE_DS: full = 20'd160705;
			NOTE_E: full = 20'd151685;
			NOTE_F: full = 20'd143172;
			NOTE_FS: full = 20'd135139;
			NOTE_G: full = 20'd127551;
			NOTE_GS: full = 20'd120395;
			NOTE_A: full = 20'd113636;
			NOTE_AS: full = 20'd107260;
			NOTE_B: full = 20'd101239;
			default: full = 20'd0;
		endcase
		return full >> `NOTE_SCALE;
	endfunction

	// Top row of the pad and no press are silent
	always_comb begin
		if (pressed && key < 4'd12)
			note_left = note_t'(key);
		else
			note_left = NOTE_REST;
	end

	// Chorus voice a major third up and folded back into the octave
	always_comb begin
		logic [3:0] step;
		step = 4'(note_left) + 4'd4;
		if (step >= 4'd12)
			step = step - 4'd12;
		if (chorus && note_left != NOTE_REST)
			note_right = note_t'(step);
		else
			note_right = note_left;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			note_div <= '0;
		end else begin
			note_div.left <= half_period(note_left);
			note_div.right <= half_period(note_right);
		end
	end

	// A rest silences both voices on the next cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		(!pressed || key >= 4'd12) |=> (note_div == '0));

endmodule

`default_nettype wire

// File: tb/speaker_input.txt
# key pressed chorus left_frames right_frames
# Frames are sign-run lengths in 128-cycle frames, 0 means silence
0 1 0 23 23
1 1 0 22 22
2 1 0 21 21
3 1 0 20 20
4 1 0 19 19
5 1 0 17 17
6 1 0 16 16
7 1 0 16 16
8 1 0 15 15
9 1 0 14 14
10 1 0 13 13
11 1 0 12 12
3 0 0 0 0
0 1 1 23 19
4 1 1 19 15
7 1 1 16 12
9 1 1 14 22
11 1 1 12 20
12 1 0 0 0
5 1 0 17 17
14 1 1 0 0
2 1 1 21 16
15 1 0 0 0

// File: tb/speaker_tb.sv
`timescale 1ns/100ps
`default_nettype none

module speaker_tb;

	localparam int FRAME_CYCLES = 128;
	localparam int FRAME_TIMEOUT = 4 * FRAME_CYCLES;
	// Zero within 300 cycles plus one frame to shift it out
	localparam int SILENCE_LIMIT = 300 + FRAME_CYCLES;
	localparam int RUN_FRAME_LIMIT = 120;
	localparam logic [15:0] VOL_POS = 16'h3FFF;
	// Two's complement of the positive level
	localparam logic [15:0] VOL_NEG = 16'hC001;

	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} frame_t;

	logic clk = 1'b0;
	logic rst_n;
	logic chorus;
	logic [3:0] col_in;
	logic [3:0] row_scn;
	logic audio_appsel;
	logic audio_sysclk;
	logic audio_bck;
	logic audio_ws;
	logic audio_data;

	logic [3:0] held_key;
	logic held_pressed;
	logic [19:0] lfsr;

	logic bck_q;
	logic ws_q;
	logic [5:0] bit_cnt;
	logic [31:0] frame_sr;
	frame_t dec_frame;
	int frame_cnt;

	logic [3:0] row_prev;
	logic [3:0] rows_seen;
	logic sysclk_prev;
	int row_errors;
	int value_errors;
	int other_fails;
	logic timed_out;

	speaker speaker_i (
		.clk(clk),
		.rst_n(rst_n),
		.chorus(chorus),
		.col_in(col_in),
		.row_scn(row_scn),
		.audio_appsel(audio_appsel),
		.audio_sysclk(audio_sysclk),
		.audio_bck(audio_bck),
		.audio_ws(audio_ws),
		.audio_data(audio_data)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// Keypad model
	//////////////////////////////////////////////////
	function automatic logic [3:0] keypad_cols(input logic [3:0] rows, input logic [3:0] key,
		input logic down);
		logic [3:0] cols;
		cols = 4'hF;
		if (down && !rows[key[3:2]])
			cols[key[1:0]] = 1'b0;
		return cols;
	endfunction

	initial begin
		logic [3:0] key_now;
		logic down_now;
		col_in = 4'hF;
		forever begin
			@(posedge clk);
			// Held key only moves 1 ns after an edge
			key_now = held_key;
			down_now = held_pressed;
			#1;
			col_in = keypad_cols(row_scn, key_now, down_now);
		end
	end

	//////////////////////////////////////////////////
	// Serial frame decoder, sampled on rising bck
	//////////////////////////////////////////////////
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bck_q <= 1'b0;
			ws_q <= 1'b1;
			bit_cnt <= 6'd0;
			frame_sr <= 32'd0;
			dec_frame <= '0;
			frame_cnt <= 0;
		end else begin
			bck_q <= audio_bck;
			if (audio_bck && !bck_q) begin
				ws_q <= audio_ws;
				if (ws_q && !audio_ws) begin
					// Left word starts a new frame
					frame_sr <= {31'd0, audio_data};
					bit_cnt <= 6'd1;
				end else begin
					frame_sr <= {frame_sr[30:0], audio_data};
					bit_cnt <= bit_cnt + 6'd1;
					if (bit_cnt == 6'd31) begin
						dec_frame <= {frame_sr[30:0], audio_data};
						frame_cnt <= frame_cnt + 1;
					end
				end
			end
		end
	end

	// Row rotation, appsel and sysclk monitor
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_prev <= 4'b1110;
			rows_seen <= 4'b0000;
			sysclk_prev <= 1'b1;
			row_errors <= 0;
		end else begin
			row_prev <= row_scn;
			rows_seen <= rows_seen | ~row_scn;
			sysclk_prev <= audio_sysclk;
			if ($countones(~row_scn) != 1) begin
				$display("ERROR at %0t: row_scn %b has not exactly one low bit", $time, row_scn);
				row_errors <= row_errors + 1;
			end else if (row_scn != row_prev && row_scn != {row_prev[2:0], row_prev[3]}) begin
				$display("ERROR at %0t: row_scn went %b to %b", $time, row_prev, row_scn);
				row_errors <= row_errors + 1;
			end else if (audio_appsel !== 1'b1) begin
				$display("ERROR at %0t: audio_appsel is %b", $time, audio_appsel);
				row_errors <= row_errors + 1;
			end else if (audio_sysclk === sysclk_prev) begin
				$display("ERROR at %0t: audio_sysclk stayed %b for two cycles",
					$time, audio_sysclk);
				row_errors <= row_errors + 1;
			end
		end
	end

	function automatic logic [19:0] lfsr_next(input logic [19:0] state);
		// Taps 20 and 17
		return {state[18:0], state[19] ^ state[16]};
	endfunction

	task automatic random_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 4; b++) begin
			lfsr = lfsr_next(lfsr);
			gap = gap * 2 + (lfsr[0] ? 1 : 0);
		end
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		value_errors++;
	endtask

	task automatic next_frame(output frame_t f, output int waited);
		int start;
		start = frame_cnt;
		waited = 0;
		f = '0;
		if (!timed_out) begin
			while (frame_cnt == start && waited < FRAME_TIMEOUT) begin
				@(posedge clk);
				waited++;
			end
			if (frame_cnt == start) begin
				$display("Timed out: no audio frame decoded in %0d clock cycles", FRAME_TIMEOUT);
				other_fails++;
				timed_out = 1'b1;
			end else begin
				f = dec_frame;
			end
		end
	endtask

	task automatic drive_inputs(input int key, input int down, input int chorus_on);
		@(posedge clk);
		#1;
		held_key = 4'(key);
		held_pressed = (down != 0);
		chorus = (chorus_on != 0);
	endtask

	task automatic check_idle_after_reset();
		frame_t f;
		int waited;
		for (int i = 0; i < 4; i++) begin
			next_frame(f, waited);
			if (!timed_out && f != '0)
				report_mismatch($sformatf("after reset left %h right %h, expected zero",
					f.left, f.right));
		end
	endtask

	task automatic check_silence(input int key);
		frame_t f;
		int waited;
		int total;
		next_frame(f, waited);
		total = waited;
		while (!timed_out && f != '0 && total <= SILENCE_LIMIT) begin
			next_frame(f, waited);
			total += waited;
		end
		if (timed_out)
			return;
		if (f != '0 || total > SILENCE_LIMIT) begin
			report_mismatch($sformatf("key %0d not silent within %0d cycles", key, SILENCE_LIMIT));
			return;
		end
		// Must stay silent
		for (int i = 0; i < 3; i++) begin
			next_frame(f, waited);
			if (!timed_out && f != '0)
				report_mismatch($sformatf("key %0d silence broken, left %h right %h",
					key, f.left, f.right));
		end
	endtask

	task automatic check_level(input int key, input logic [15:0] v, input string side);
		if (v != VOL_POS && v != VOL_NEG)
			report_mismatch($sformatf("key %0d %s sample %h is not full volume", key, side, v));
	endtask

	task automatic check_run(input int key, input int len, input int expected, input string side);
		if (len < expected - 1 || len > expected + 1)
			report_mismatch($sformatf("key %0d %s run %0d frames, expected %0d",
				key, side, len, expected));
	endtask

	task automatic measure_tone(input int key, input int exp_left, input int exp_right,
		input int chorus_on);
		frame_t f;
		int waited;
		int frames;
		int runs_l;
		int runs_r;
		int len_l;
		int len_r;
		logic sign_l;
		logic sign_r;
		// Let the new note reach the serial output
		for (int i = 0; i < 4; i++)
			next_frame(f, waited);
		frames = 0;
		runs_l = 0;
		runs_r = 0;
		len_l = 1;
		len_r = 1;
		sign_l = f.left[15];
		sign_r = f.right[15];
		while (!timed_out && (runs_l < 3 || runs_r < 3) && frames < RUN_FRAME_LIMIT) begin
			next_frame(f, waited);
			frames++;
			if (!timed_out) begin
				check_level(key, f.left, "left");
				check_level(key, f.right, "right");
				if (chorus_on == 0 && f.left != f.right)
					report_mismatch($sformatf("key %0d left %h and right %h differ",
						key, f.left, f.right));
				// First run began before measuring so it is skipped
				if (f.left[15] == sign_l) begin
					len_l++;
				end else begin
					if (runs_l > 0)
						check_run(key, len_l, exp_left, "left");
					runs_l++;
					sign_l = f.left[15];
					len_l = 1;
				end
				if (f.right[15] == sign_r) begin
					len_r++;
				end else begin
					if (runs_r > 0)
						check_run(key, len_r, exp_right, "right");
					runs_r++;
					sign_r = f.right[15];
					len_r = 1;
				end
			end
		end
		if (!timed_out && (runs_l < 3 || runs_r < 3)) begin
			$display("Key %0d: tone did not change sign often enough in %0d frames",
				key, RUN_FRAME_LIMIT);
			other_fails++;
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		int fd;
		int n;
		int key_v;
		int down_v;
		int chorus_v;
		int exp_l;
		int exp_r;
		int gap;
		int vectors;
		string line;
		rst_n = 1'b0;
		chorus = 1'b0;
		held_key = 4'd0;
		held_pressed = 1'b0;
		lfsr = 20'd80441;
		value_errors = 0;
		other_fails = 0;
		timed_out = 1'b0;
		vectors = 0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		check_idle_after_reset();

		fd = $fopen("tb/speaker_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tb/speaker_input.txt");
			other_fails++;
		end else begin
			while (!timed_out && !$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && $sscanf(line, "%d %d %d %d %d",
					key_v, down_v, chorus_v, exp_l, exp_r) == 5) begin
					vectors++;
					random_gap(gap);
					repeat (gap) @(posedge clk);
					drive_inputs(key_v, down_v, chorus_v);
					if (exp_l == 0 && exp_r == 0)
						check_silence(key_v);
					else
						measure_tone(key_v, exp_l, exp_r, chorus_v);
				end
			end
			$fclose(fd);
		end
		if (vectors == 0) begin
			$display("No test vectors were read from the vector file");
			other_fails++;
		end
		if (rows_seen != 4'hF) begin
			$display("Not every keypad row was driven low, rows seen %b", rows_seen);
			other_fails++;
		end

		$display("Errors: %0d value mismatches, %0d port errors, %0d other failures",
			value_errors, row_errors, other_fails);
		if (value_errors == 0 && row_errors == 0 && other_fails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
